//--- include/axil_xbar_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time sizes and address map of the AXI4-Lite
// read crossbar, included by packages and RTL
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AXIL_XBAR_CONFIG_SVH
`define AXIL_XBAR_CONFIG_SVH

// bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// port counts, arbiter needs at least two managers
`define XBAR_MST_NUM 2
`define XBAR_SLV_NUM 2

// subordinate 0 window
`define XBAR_SLV0_LOW  32'h0000_0000
`define XBAR_SLV0_HIGH 32'h0000_FFFF

// subordinate 1 window
`define XBAR_SLV1_LOW  32'h0001_0000
`define XBAR_SLV1_HIGH 32'h0001_FFFF

`endif

//--- logic/axil_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite read channel types, shared by the RTL
// and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_xbar_config.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;
    typedef logic [2:0]                  prot_t;

    // encoding as on the bus
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage

//--- logic/xbar_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types internal to the read crossbar: FSM states,
// port selectors and the address decode result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_xbar_config.svh"

package xbar_pkg;

    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b10
    } rd_state_e;

    // manager and subordinate indices
    typedef logic [$clog2(`XBAR_MST_NUM)-1:0] mst_sel_t;
    typedef logic [$clog2(`XBAR_SLV_NUM)-1:0] slv_sel_t;

    // hit low means the address is outside every window
    typedef struct packed {
        slv_sel_t slv;
        logic     hit;
    } route_t;

endpackage

//--- logic/rd_grant_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grant handoff from the read arbiter to the read
// transaction controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface rd_grant_if import axil_pkg::*, xbar_pkg::*; ();

    logic     grant;
    mst_sel_t mst;
    route_t   route;
    prot_t    prot;

    // controller status back to the arbiter
    logic     idle;
    logic     done;

    modport arbiter (
        output grant, mst, route, prot,
        input  idle, done
    );

    modport ctrl (
        input  grant, mst, route, prot,
        output idle, done
    );

endinterface

//--- logic/rd_route_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Active route from the read controller to the
// path steering, with handshake completions back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface rd_route_if import axil_pkg::*, xbar_pkg::*; ();

    rd_state_e state;
    mst_sel_t  mst;
    route_t    route;
    prot_t     prot;

    // address and data handshakes as seen by the manager
    logic      ar_fire;
    logic      r_fire;

    modport ctrl (
        output state, mst, route, prot,
        input  ar_fire, r_fire
    );

    modport steer (
        input  state, mst, route, prot,
        output ar_fire, r_fire
    );

endinterface

//--- logic/ar_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin read address arbiter with decode of
// the winning address onto the subordinate windows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "axil_xbar_config.svh"

module ar_arbiter import axil_pkg::*, xbar_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  addr_t [`XBAR_MST_NUM-1:0]    araddr_i,
    input  prot_t [`XBAR_MST_NUM-1:0]    arprot_i,
    input  logic  [`XBAR_MST_NUM-1:0]    arvalid_i,
    rd_grant_if.arbiter                  grant_o
);

    mst_sel_t prio_q;
    mst_sel_t served_q;
    mst_sel_t winner;

    // first matching window wins
    function automatic route_t decode_addr(input addr_t addr);
        route_t rt;
        rt = '0;
        if (addr >= `XBAR_SLV0_LOW && addr <= `XBAR_SLV0_HIGH) begin
            rt.slv = slv_sel_t'(0);
            rt.hit = 1'b1;
        end else if (addr >= `XBAR_SLV1_LOW && addr <= `XBAR_SLV1_HIGH) begin
            rt.slv = slv_sel_t'(1);
            rt.hit = 1'b1;
        end
        return rt;
    endfunction

    // search from the priority pointer upwards, lowest offset wins
    always_comb begin
        mst_sel_t cand;
        winner = prio_q;
        for (int k = `XBAR_MST_NUM - 1; k >= 0; k--) begin
            cand = mst_sel_t'((int'(prio_q) + k) % `XBAR_MST_NUM);
            if (arvalid_i[cand]) begin
                winner = cand;
            end
        end
    end

    assign grant_o.grant = grant_o.idle && (|arvalid_i);
    assign grant_o.mst   = winner;
    assign grant_o.route = decode_addr(araddr_i[winner]);
    assign grant_o.prot  = arprot_i[winner];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prio_q   <= '0;
            served_q <= '0;
        end else begin
            if (grant_o.grant) begin
                served_q <= winner;
            end
            // move past the manager that just finished
            if (grant_o.done) begin
                prio_q <= mst_sel_t'((int'(served_q) + 1) % `XBAR_MST_NUM);
            end
        end
    end

    // the controller must leave idle right after taking a grant
    a_grant_leaves_idle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        grant_o.grant |=> !grant_o.idle
    );

endmodule

//--- logic/rd_txn_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read transaction FSM: takes one grant at a time
// and walks it through address and data phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rd_txn_ctrl import axil_pkg::*, xbar_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    rd_grant_if.ctrl   grant_i,
    rd_route_if.ctrl   route_o
);

    rd_state_e state_q;
    rd_state_e state_d;
    mst_sel_t  mst_q;
    route_t    route_q;
    prot_t     prot_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (grant_i.grant) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (route_o.ar_fire) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (route_o.r_fire) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // transaction context, captured with the grant
    always_ff @(posedge clk_i) begin
        if (state_q == RD_IDLE && grant_i.grant) begin
            mst_q   <= grant_i.mst;
            route_q <= grant_i.route;
            prot_q  <= grant_i.prot;
        end
    end

    assign grant_i.idle = (state_q == RD_IDLE);
    assign grant_i.done = (state_q == RD_DATA) && route_o.r_fire;

    assign route_o.state = state_q;
    assign route_o.mst   = mst_q;
    assign route_o.route = route_q;
    assign route_o.prot  = prot_q;

    // steering must only complete the phase the FSM is in
    a_ar_fire_in_addr: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        route_o.ar_fire |-> state_q == RD_ADDR
    );

    a_r_fire_in_data: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        route_o.r_fire |-> state_q == RD_DATA
    );

endmodule

//--- logic/rd_path_steer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational AR/R steering between the granted
// manager and the routed subordinate, or DECERR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "axil_xbar_config.svh"

module rd_path_steer import axil_pkg::*, xbar_pkg::*; (
    rd_route_if.steer                    route_i,
    input  addr_t [`XBAR_MST_NUM-1:0]    m_araddr_i,
    input  logic  [`XBAR_MST_NUM-1:0]    m_rready_i,
    output logic  [`XBAR_MST_NUM-1:0]    m_arready_o,
    output data_t [`XBAR_MST_NUM-1:0]    m_rdata_o,
    output resp_e [`XBAR_MST_NUM-1:0]    m_rresp_o,
    output logic  [`XBAR_MST_NUM-1:0]    m_rvalid_o,
    output addr_t [`XBAR_SLV_NUM-1:0]    s_araddr_o,
    output prot_t [`XBAR_SLV_NUM-1:0]    s_arprot_o,
    output logic  [`XBAR_SLV_NUM-1:0]    s_arvalid_o,
    output logic  [`XBAR_SLV_NUM-1:0]    s_rready_o,
    input  logic  [`XBAR_SLV_NUM-1:0]    s_arready_i,
    input  data_t [`XBAR_SLV_NUM-1:0]    s_rdata_i,
    input  resp_e [`XBAR_SLV_NUM-1:0]    s_rresp_i,
    input  logic  [`XBAR_SLV_NUM-1:0]    s_rvalid_i
);

    mst_sel_t mst;
    slv_sel_t slv;
    logic     hit;

    assign mst = route_i.mst;
    assign slv = route_i.route.slv;
    assign hit = route_i.route.hit;

    always_comb begin
        m_arready_o     = '0;
        m_rvalid_o      = '0;
        m_rdata_o       = '0;
        m_rresp_o       = {`XBAR_MST_NUM{RESP_OKAY}};
        s_araddr_o      = '0;
        s_arprot_o      = '0;
        s_arvalid_o     = '0;
        s_rready_o      = '0;
        route_i.ar_fire = 1'b0;
        route_i.r_fire  = 1'b0;

        case (route_i.state)
            RD_ADDR: begin
                if (hit) begin
                    // manager keeps arvalid up until arready
                    s_araddr_o[slv]  = m_araddr_i[mst];
                    s_arprot_o[slv]  = route_i.prot;
                    s_arvalid_o[slv] = 1'b1;
                    m_arready_o[mst] = s_arready_i[slv];
                    route_i.ar_fire  = s_arready_i[slv];
                end else begin
                    // decode miss, accept locally
                    m_arready_o[mst] = 1'b1;
                    route_i.ar_fire  = 1'b1;
                end
            end
            RD_DATA: begin
                if (hit) begin
                    s_rready_o[slv] = m_rready_i[mst];
                    m_rvalid_o[mst] = s_rvalid_i[slv];
                    m_rdata_o[mst]  = s_rdata_i[slv];
                    m_rresp_o[mst]  = s_rresp_i[slv];
                    route_i.r_fire  = s_rvalid_i[slv] && m_rready_i[mst];
                end else begin
                    m_rvalid_o[mst] = 1'b1;
                    m_rdata_o[mst]  = '0;
                    m_rresp_o[mst]  = RESP_DECERR;
                    route_i.r_fire  = m_rready_i[mst];
                end
            end
            default: ;
        endcase
    end

    // a forwarded address must lie in the window of its subordinate
    always_comb begin
        a_slv0_in_window: assert final (!s_arvalid_o[0] ||
            (s_araddr_o[0] >= `XBAR_SLV0_LOW && s_araddr_o[0] <= `XBAR_SLV0_HIGH));
        a_slv1_in_window: assert final (!s_arvalid_o[1] ||
            (s_araddr_o[1] >= `XBAR_SLV1_LOW && s_araddr_o[1] <= `XBAR_SLV1_HIGH));
    end

endmodule

//--- logic/axil_rd_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite read crossbar top, two managers to two
// subordinates, one read in flight at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "axil_xbar_config.svh"

module axil_rd_xbar import axil_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // manager side
    input  addr_t [`XBAR_MST_NUM-1:0]    m_araddr_i,
    input  prot_t [`XBAR_MST_NUM-1:0]    m_arprot_i,
    input  logic  [`XBAR_MST_NUM-1:0]    m_arvalid_i,
    input  logic  [`XBAR_MST_NUM-1:0]    m_rready_i,
    output logic  [`XBAR_MST_NUM-1:0]    m_arready_o,
    output data_t [`XBAR_MST_NUM-1:0]    m_rdata_o,
    output resp_e [`XBAR_MST_NUM-1:0]    m_rresp_o,
    output logic  [`XBAR_MST_NUM-1:0]    m_rvalid_o,

    // subordinate side
    output addr_t [`XBAR_SLV_NUM-1:0]    s_araddr_o,
    output prot_t [`XBAR_SLV_NUM-1:0]    s_arprot_o,
    output logic  [`XBAR_SLV_NUM-1:0]    s_arvalid_o,
    output logic  [`XBAR_SLV_NUM-1:0]    s_rready_o,
    input  logic  [`XBAR_SLV_NUM-1:0]    s_arready_i,
    input  data_t [`XBAR_SLV_NUM-1:0]    s_rdata_i,
    input  resp_e [`XBAR_SLV_NUM-1:0]    s_rresp_i,
    input  logic  [`XBAR_SLV_NUM-1:0]    s_rvalid_i
);

    rd_grant_if i_rd_grant_if ();
    rd_route_if i_rd_route_if ();

    ar_arbiter i_ar_arbiter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .araddr_i  (m_araddr_i),
        .arprot_i  (m_arprot_i),
        .arvalid_i (m_arvalid_i),
        .grant_o   (i_rd_grant_if.arbiter)
    );

    rd_txn_ctrl i_rd_txn_ctrl (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .grant_i (i_rd_grant_if.ctrl),
        .route_o (i_rd_route_if.ctrl)
    );

    rd_path_steer i_rd_path_steer (
        .route_i     (i_rd_route_if.steer),
        .m_araddr_i  (m_araddr_i),
        .m_rready_i  (m_rready_i),
        .m_arready_o (m_arready_o),
        .m_rdata_o   (m_rdata_o),
        .m_rresp_o   (m_rresp_o),
        .m_rvalid_o  (m_rvalid_o),
        .s_araddr_o  (s_araddr_o),
        .s_arprot_o  (s_arprot_o),
        .s_arvalid_o (s_arvalid_o),
        .s_rready_o  (s_rready_o),
        .s_arready_i (s_arready_i),
        .s_rdata_i   (s_rdata_i),
        .s_rresp_i   (s_rresp_i),
        .s_rvalid_i  (s_rvalid_i)
    );

endmodule

//--- verif/tb_axil_rd_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the AXI4-Lite read
// crossbar, with subordinate models and a checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "axil_xbar_config.svh"

module tb_axil_rd_xbar import axil_pkg::*; ();

    localparam int MN = `XBAR_MST_NUM;
    localparam int SN = `XBAR_SLV_NUM;
    localparam data_t SLV0_KEY = 32'hA5A5_0F0F;
    localparam data_t SLV1_KEY = 32'h3C3C_5A5A;
    localparam int ALT_READS = 6;
    localparam int STALL_CYCLES = 10;
    // 8 window reads, 4 misses, two streams, one stalled pair
    localparam int NUM_READS = 8 + 4 + 2 * ALT_READS + 2;
    localparam int CYC_PER_READ = 16;
    localparam int TEST_CYCLES = NUM_READS * CYC_PER_READ + STALL_CYCLES + 3 * 5 + 20;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic clk_i;
    logic rstn_i;
    addr_t [MN-1:0] m_araddr_i;
    prot_t [MN-1:0] m_arprot_i;
    logic  [MN-1:0] m_arvalid_i;
    logic  [MN-1:0] m_rready_i;
    logic  [MN-1:0] m_arready_o;
    data_t [MN-1:0] m_rdata_o;
    resp_e [MN-1:0] m_rresp_o;
    logic  [MN-1:0] m_rvalid_o;
    addr_t [SN-1:0] s_araddr_o;
    prot_t [SN-1:0] s_arprot_o;
    logic  [SN-1:0] s_arvalid_o;
    logic  [SN-1:0] s_rready_o;
    logic  [SN-1:0] s_arready_i;
    data_t [SN-1:0] s_rdata_i;
    resp_e [SN-1:0] s_rresp_i;
    logic  [SN-1:0] s_rvalid_i;

    integer seed = 57077;
    int     err_count = 0;
    int     cycle_cnt = 0;
    logic   [MN-1:0] rready_hold;
    addr_t  pend_addr[$];
    int     pend_mst[$];
    int     done_order[$];
    int     done_cnt[MN];
    // subordinate model state
    logic   slv_busy[SN];
    int     ar_wait[SN];
    int     r_wait[SN];
    addr_t  held_addr[SN];

    axil_rd_xbar i_axil_rd_xbar (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .m_araddr_i  (m_araddr_i),
        .m_arprot_i  (m_arprot_i),
        .m_arvalid_i (m_arvalid_i),
        .m_rready_i  (m_rready_i),
        .m_arready_o (m_arready_o),
        .m_rdata_o   (m_rdata_o),
        .m_rresp_o   (m_rresp_o),
        .m_rvalid_o  (m_rvalid_o),
        .s_araddr_o  (s_araddr_o),
        .s_arprot_o  (s_arprot_o),
        .s_arvalid_o (s_arvalid_o),
        .s_rready_o  (s_rready_o),
        .s_arready_i (s_arready_i),
        .s_rdata_i   (s_rdata_i),
        .s_rresp_i   (s_rresp_i),
        .s_rvalid_i  (s_rvalid_i)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string what);
        err_count++;
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // -1 means outside every window
    function automatic int ref_target(input addr_t addr);
        if (addr >= `XBAR_SLV0_LOW && addr <= `XBAR_SLV0_HIGH) begin
            return 0;
        end else if (addr >= `XBAR_SLV1_LOW && addr <= `XBAR_SLV1_HIGH) begin
            return 1;
        end
        return -1;
    endfunction

    function automatic data_t slv_key(input int s);
        return (s == 0) ? SLV0_KEY : SLV1_KEY;
    endfunction

    function automatic void ref_read(input addr_t addr, output data_t data, output resp_e resp);
        int tgt;
        tgt = ref_target(addr);
        if (tgt < 0) begin
            data = '0;
            resp = RESP_DECERR;
        end else begin
            data = addr ^ slv_key(tgt);
            resp = RESP_OKAY;
        end
    endfunction

    // prot follows the address so the checker can predict it
    function automatic prot_t prot_for(input addr_t addr);
        return prot_t'(addr[6:4]);
    endfunction

    function automatic addr_t hit_addr(input int k);
        case (k)
            0: return 32'h0000_0010;
            1: return 32'h0000_FFFC;
            2: return 32'h0001_0000;
            default: return 32'h0001_ABC8;
        endcase
    endfunction

    // call on a rising edge, returns on the AR handshake edge
    task automatic do_read(input int m, input addr_t addr, input bit keep_valid);
        m_araddr_i[m]  <= addr;
        m_arprot_i[m]  <= prot_for(addr);
        m_arvalid_i[m] <= 1'b1;
        do begin
            @(posedge clk_i);
        end while (!(m_arvalid_i[m] && m_arready_o[m]));
        if (!keep_valid) begin
            m_arvalid_i[m] <= 1'b0;
        end
    endtask

    task automatic run_stream(input int m, input int n);
        addr_t addr;
        for (int i = 0; i < n; i++) begin
            addr = addr_t'($random(seed)) & 32'h0002_FFFC;
            do_read(m, addr, i < n - 1);
        end
    endtask

    task automatic wait_idle();
        @(posedge clk_i);
        while (pend_addr.size() != 0 || m_arvalid_i != '0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic apply_reset();
        rstn_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
    endtask

    // subordinates with random address and data latency
    always @(posedge clk_i or negedge rstn_i) begin : slv_model
        if (!rstn_i) begin
            s_arready_i <= '0;
            s_rvalid_i  <= '0;
            s_rdata_i   <= '0;
            s_rresp_i   <= {SN{RESP_OKAY}};
            for (int s = 0; s < SN; s++) begin
                slv_busy[s] <= 1'b0;
                ar_wait[s]  <= 0;
                r_wait[s]   <= 0;
            end
        end else begin
            for (int s = 0; s < SN; s++) begin
                if (!slv_busy[s]) begin
                    if (s_arvalid_o[s] && s_arready_i[s]) begin
                        s_arready_i[s] <= 1'b0;
                        slv_busy[s]    <= 1'b1;
                        held_addr[s]   <= s_araddr_o[s];
                        r_wait[s]      <= $random(seed) & 3;
                    end else if (s_arvalid_o[s]) begin
                        if (ar_wait[s] == 0) begin
                            s_arready_i[s] <= 1'b1;
                        end else begin
                            ar_wait[s] <= ar_wait[s] - 1;
                        end
                    end
                end else if (s_rvalid_i[s]) begin
                    if (s_rready_o[s]) begin
                        s_rvalid_i[s] <= 1'b0;
                        slv_busy[s]   <= 1'b0;
                        ar_wait[s]    <= $random(seed) & 3;
                    end
                end else if (r_wait[s] == 0) begin
                    s_rvalid_i[s] <= 1'b1;
                    s_rdata_i[s]  <= held_addr[s] ^ slv_key(s);
                    s_rresp_i[s]  <= RESP_OKAY;
                end else begin
                    r_wait[s] <= r_wait[s] - 1;
                end
            end
        end
    end

    always @(posedge clk_i) begin : rready_drive
        for (int m = 0; m < MN; m++) begin
            m_rready_i[m] <= !rready_hold[m] && (($random(seed) & 1) != 0);
        end
    end

    always @(posedge clk_i) begin : check_proc
        data_t exp_data;
        resp_e exp_resp;
        addr_t addr;
        int    mst;
        logic  exp_rready;
        if (rstn_i) begin
            // a busy subordinate sees the rready of the manager it serves
            for (int s = 0; s < SN; s++) begin
                exp_rready = (slv_busy[s] && pend_mst.size() != 0) ?
                             m_rready_i[pend_mst[0]] : 1'b0;
                assert (s_rready_o[s] == exp_rready) else
                    abort_run($sformatf("ERROR s_rready_o[%0d]: got 0x%0h expected 0x%0h",
                                        s, s_rready_o[s], exp_rready));
            end
            for (int m = 0; m < MN; m++) begin
                if (m_arvalid_i[m] && m_arready_o[m]) begin
                    pend_addr.push_back(m_araddr_i[m]);
                    pend_mst.push_back(m);
                end
                if (m_rvalid_o[m] && m_rready_i[m]) begin
                    assert (pend_addr.size() != 0) else
                        abort_run($sformatf("manager %0d got read data with no read pending", m));
                    addr = pend_addr.pop_front();
                    mst  = pend_mst.pop_front();
                    assert (mst == m) else
                        abort_run($sformatf("read from manager %0d was answered on manager %0d",
                                            mst, m));
                    ref_read(addr, exp_data, exp_resp);
                    assert (m_rdata_o[m] == exp_data) else
                        abort_run($sformatf("ERROR m_rdata_o[%0d]: got 0x%08h expected 0x%08h",
                                            m, m_rdata_o[m], exp_data));
                    assert (m_rresp_o[m] == exp_resp) else
                        abort_run($sformatf("ERROR m_rresp_o[%0d]: got 0x%0h expected 0x%0h",
                                            m, m_rresp_o[m], exp_resp));
                    done_cnt[m]++;
                    done_order.push_back(m);
                end
            end
            for (int s = 0; s < SN; s++) begin
                if (s_arvalid_o[s]) begin
                    assert (ref_target(s_araddr_o[s]) == s) else
                        abort_run($sformatf("address 0x%08h was sent to subordinate %0d",
                                            s_araddr_o[s], s));
                    assert (s_arprot_o[s] == prot_for(s_araddr_o[s])) else
                        abort_run($sformatf("ERROR s_arprot_o[%0d]: got 0x%0h expected 0x%0h",
                                            s, s_arprot_o[s], prot_for(s_araddr_o[s])));
                end else begin
                    assert (s_araddr_o[s] == '0) else
                        abort_run($sformatf("ERROR s_araddr_o[%0d]: got 0x%08h expected 0x0",
                                            s, s_araddr_o[s]));
                    assert (s_arprot_o[s] == '0) else
                        abort_run($sformatf("ERROR s_arprot_o[%0d]: got 0x%0h expected 0x0",
                                            s, s_arprot_o[s]));
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin : main_proc
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        m_araddr_i  = '0;
        m_arprot_i  = '0;
        m_arvalid_i = '0;
        m_rready_i  = '0;
        s_arready_i = '0;
        s_rdata_i   = '0;
        s_rresp_i   = {SN{RESP_OKAY}};
        s_rvalid_i  = '0;
        rready_hold = '0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        // quiet bus before the first request
        repeat (4) begin
            @(posedge clk_i);
            assert (m_arready_o == '0) else
                abort_run($sformatf("ERROR m_arready_o: got 0x%0h expected 0x0", m_arready_o));
            assert (m_rvalid_o == '0) else
                abort_run($sformatf("ERROR m_rvalid_o: got 0x%0h expected 0x0", m_rvalid_o));
            assert (s_arvalid_o == '0) else
                abort_run($sformatf("ERROR s_arvalid_o: got 0x%0h expected 0x0", s_arvalid_o));
        end

        for (int m = 0; m < MN; m++) begin
            for (int k = 0; k < 4; k++) begin
                do_read(m, hit_addr(k), 1'b0);
                wait_idle();
            end
        end

        // decode misses
        for (int m = 0; m < MN; m++) begin
            do_read(m, 32'h0002_0000, 1'b0);
            wait_idle();
            do_read(m, 32'hFFFF_FFF0, 1'b0);
            wait_idle();
        end

        // both managers busy, priority starts at manager 0
        apply_reset();
        done_order.delete();
        fork
            run_stream(0, ALT_READS);
            run_stream(1, ALT_READS);
        join
        wait_idle();
        assert (done_order.size() == 2 * ALT_READS) else
            abort_run($sformatf("%0d reads completed in the alternation test, expected %0d",
                                done_order.size(), 2 * ALT_READS));
        for (int i = 0; i < 2 * ALT_READS; i++) begin
            assert (done_order[i] == i % 2) else
                abort_run($sformatf("read %0d completed on manager %0d, expected manager %0d",
                                    i, done_order[i], i % 2));
        end

        // stall manager 0 in the data phase
        rready_hold[0] <= 1'b1;
        @(posedge clk_i);
        do_read(0, 32'h0001_2340, 1'b0);
        fork
            do_read(1, 32'h0000_0440, 1'b0);
            begin
                repeat (STALL_CYCLES) begin
                    @(posedge clk_i);
                    assert (m_arready_o[1] == 1'b0) else
                        abort_run("ERROR m_arready_o[1]: got 0x1 expected 0x0");
                end
                // read data stays offered while rready is low
                assert (m_rvalid_o[0] == 1'b1) else
                    abort_run("ERROR m_rvalid_o[0]: got 0x0 expected 0x1");
                rready_hold[0] <= 1'b0;
            end
        join
        wait_idle();

        assert (done_cnt[0] + done_cnt[1] == NUM_READS) else
            abort_run($sformatf("%0d reads completed, expected %0d",
                                done_cnt[0] + done_cnt[1], NUM_READS));
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- axil_rd_xbar.f
+incdir+include
logic/axil_pkg.sv
logic/xbar_pkg.sv
logic/rd_grant_if.sv
logic/rd_route_if.sv
logic/ar_arbiter.sv
logic/rd_txn_ctrl.sv
logic/rd_path_steer.sv
logic/axil_rd_xbar.sv
verif/tb_axil_rd_xbar.sv

//--- Bender.yml
package:
  name: axil_rd_xbar

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/axil_pkg.sv
      - logic/xbar_pkg.sv
      - logic/rd_grant_if.sv
      - logic/rd_route_if.sv
      - logic/ar_arbiter.sv
      - logic/rd_txn_ctrl.sv
      - logic/rd_path_steer.sv
      - logic/axil_rd_xbar.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_axil_rd_xbar.sv
